/* source/opc5_pkg.sv */
`default_nettype none

package opc5_pkg;

   // ========================================
   // widths and sizes
   // ========================================
   localparam int DATA_W     = 16;
   localparam int REG_COUNT  = 16;
   localparam int PC_REG     = 15;   // register index aliased to the program counter
   localparam int MEM_ADDR_W = 10;   // 1024 words, aliases above

   // ========================================
   // opcodes and sequencer states
   // ========================================
   typedef enum logic [2:0] {
      op_ld  = 3'd0,
      op_add = 3'd1,
      op_and = 3'd2,
      op_or  = 3'd3,
      op_xor = 3'd4,
      op_ror = 3'd5,
      op_adc = 3'd6,
      op_sto = 3'd7
   } opc5_op_t;

   typedef enum logic [2:0] {
      st_fetch0 = 3'd0,
      st_fetch1 = 3'd1,
      st_ea_ed  = 3'd2,   // effective address / extended decode
      st_rdmem  = 3'd3,
      st_exec   = 3'd4,
      st_wrmem  = 3'd5
   } opc5_state_t;

   // ========================================
   // instruction word and alu result
   // ========================================
   typedef struct packed {
      logic       pred_c;
      logic       pred_z;
      logic       pinvert;
      logic       two_word;   // immediate word follows
      logic       indirect;   // operand read from memory
      opc5_op_t   opcode;
      logic [3:0] src;
      logic [3:0] dst;
   } opc5_instr_t;

   typedef struct packed {
      logic [DATA_W-1:0] result;
      logic              carry;
   } opc5_alu_out_t;

endpackage

`default_nettype wire

/* source/opc5_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module opc5_alu
   import opc5_pkg::*;
(
   input  opc5_op_t          op,
   input  logic [DATA_W-1:0] a,          // destination register value
   input  logic [DATA_W-1:0] b,          // operand
   input  logic              carry_in,
   output opc5_alu_out_t     out
);

   always_comb
   begin
      out.result = b;
      out.carry  = carry_in;             // logic ops keep carry
      case (op)
         op_ld:
         begin
            out.result = b;
         end
         op_add:
         begin
            {out.carry, out.result} = a + b;
         end
         op_adc:
         begin
            {out.carry, out.result} = a + b + carry_in;
         end
         op_and:
         begin
            out.result = a & b;
         end
         op_or:
         begin
            out.result = a | b;
         end
         op_xor:
         begin
            out.result = a ^ b;
         end
         op_ror:
         begin
            {out.result, out.carry} = {carry_in, b};   // rotate through carry
         end
         op_sto:
         begin
            out.result = b;              // not written back
         end
         default:
         begin
            out.result = b;
         end
      endcase
   end

endmodule

`default_nettype wire

/* source/opc5_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module opc5_regfile
   import opc5_pkg::*;
(
   input  logic              clk,
   input  logic [3:0]        radr_a,
   input  logic [3:0]        radr_b,
   input  logic [DATA_W-1:0] pc,
   input  logic              we,
   input  logic [3:0]        wadr,
   input  logic [DATA_W-1:0] wdata,
   output logic [DATA_W-1:0] rdata_a,
   output logic [DATA_W-1:0] rdata_b
);

   // two identical copies, one per read port
   logic [DATA_W-1:0] regs_a [REG_COUNT];
   logic [DATA_W-1:0] regs_b [REG_COUNT];

   always_ff @(posedge clk)
   begin
      if (we)
      begin
         regs_a[wadr] <= wdata;
         regs_b[wadr] <= wdata;
      end
   end

   always_comb
   begin
      if (radr_a == 4'(PC_REG))
         rdata_a = pc;
      else if (radr_a == 4'd0)
         rdata_a = '0;                  // r0 is hardwired zero
      else
         rdata_a = regs_a[radr_a];
   end

   always_comb
   begin
      if (radr_b == 4'(PC_REG))
         rdata_b = pc;
      else if (radr_b == 4'd0)
         rdata_b = '0;
      else
         rdata_b = regs_b[radr_b];
   end

   // the datapath owns the program counter, so r15 is never written here
   a_no_pc_write: assert property (@(posedge clk) we |-> (wadr != 4'(PC_REG)))
      else $error("register file write aimed at program counter alias");

endmodule

`default_nettype wire

/* source/opc5_control.sv */
`timescale 1ns/1ps
`default_nettype none

module opc5_control
   import opc5_pkg::*;
(
   input  logic        clk,
   input  logic        reset_b,
   input  opc5_instr_t bus_word,
   input  opc5_instr_t ir,
   input  logic        c_flag,
   input  logic        z_flag,
   output opc5_state_t state
);

   opc5_state_t next_state;
   logic        pred_bus;
   logic        pred_ir;
   logic        bus_always;

   function automatic logic predicate(input opc5_instr_t w, input logic c, input logic z);
      return w.pinvert ^ ((w.pred_c | c) & (w.pred_z | z));
   endfunction

   // memory access needs an effective address cycle
   function automatic logic needs_ea(input opc5_instr_t w);
      return w.indirect || (w.opcode == op_sto);
   endfunction

   assign pred_bus   = predicate(bus_word, c_flag, z_flag);
   assign pred_ir    = predicate(ir, c_flag, z_flag);
   assign bus_always = ({bus_word.pred_c, bus_word.pred_z, bus_word.pinvert} == 3'b110);

   // ========================================
   // next state
   // ========================================
   always_comb
   begin
      next_state = st_fetch0;
      case (state)
         st_fetch0:
         begin
            if (bus_word.two_word)
               next_state = st_fetch1;   // predicate checked once ir holds it
            else if (!pred_bus)
               next_state = st_fetch0;
            else if (needs_ea(bus_word))
               next_state = st_ea_ed;
            else
               next_state = st_exec;     // operand from second read port
         end
         st_fetch1:
         begin
            if (!pred_ir)
               next_state = st_fetch0;
            else if ((ir.src == 4'd0) && !needs_ea(ir))
               next_state = st_exec;
            else
               next_state = st_ea_ed;
         end
         st_ea_ed:
         begin
            if (!pred_ir)
               next_state = st_fetch0;
            else if (ir.indirect)
               next_state = st_rdmem;
            else if (ir.opcode == op_sto)
               next_state = st_wrmem;
            else
               next_state = st_exec;
         end
         st_rdmem:
            next_state = st_exec;
         st_exec:
         begin
            // flags change this cycle, so only an unconditional word may skip ea_ed
            if (ir.dst == 4'(PC_REG))
               next_state = st_fetch0;
            else if (bus_word.two_word)
               next_state = st_fetch1;
            else if (needs_ea(bus_word))
               next_state = st_ea_ed;
            else if (bus_always)
               next_state = st_exec;
            else
               next_state = st_ea_ed;
         end
         default:
            next_state = st_fetch0;      // wrmem and illegal codes
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state <= st_fetch0;
      else
         state <= next_state;
   end

   a_state_legal: assert property (@(posedge clk) disable iff (!reset_b)
      state inside {st_fetch0, st_fetch1, st_ea_ed, st_rdmem, st_exec, st_wrmem})
      else $error("sequencer in illegal state %0d", state);

   // the store word must still sit in ir when its write cycle runs
   a_wrmem_from_ea: assert property (@(posedge clk) disable iff (!reset_b)
      (state == st_wrmem) |-> (($past(state) == st_ea_ed) && (ir.opcode == op_sto)))
      else $error("wrmem entered without effective address cycle of a store");

endmodule

`default_nettype wire

/* source/opc5_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module opc5_cpu
   import opc5_pkg::*;
(
   input  logic              clk,
   input  logic              reset_b,
   inout  wire logic [DATA_W-1:0] data,
   output logic [DATA_W-1:0] address,
   output logic              rnw
);

   opc5_state_t       state;
   opc5_instr_t       bus_word;
   opc5_instr_t       ir_q;
   opc5_alu_out_t     alu_out;
   logic [DATA_W-1:0] pc_q;
   logic [DATA_W-1:0] or_q;              // immediate / effective address / mem operand
   logic [DATA_W-1:0] result_q;
   logic [DATA_W-1:0] rdata_a;
   logic [DATA_W-1:0] rdata_b;
   logic [DATA_W-1:0] operand;
   logic              c_q;
   logic              z_flag;
   logic              in_fetch;
   logic              in_exec;
   logic              in_wrmem;
   logic              rf_we;
   logic              drive_en;

   assign bus_word = data;
   assign z_flag   = (result_q == '0);

   // ========================================
   // state decode and bus drive
   // ========================================
   assign in_fetch = (state == st_fetch0) || (state == st_fetch1);
   assign in_exec  = (state == st_exec);
   assign in_wrmem = (state == st_wrmem);
   assign drive_en = in_wrmem;
   assign rnw      = !drive_en;
   assign data     = drive_en ? rdata_a : 'z;
   assign address  = (in_wrmem || (state == st_rdmem)) ? or_q : pc_q;
   assign rf_we    = in_exec && (ir_q.dst != 4'(PC_REG));

   // one word instructions take the operand straight from port b
   assign operand  = (ir_q.two_word || ir_q.indirect) ? or_q : rdata_b;

   opc5_control u_control (
      .clk     (clk),
      .reset_b (reset_b),
      .bus_word(bus_word),
      .ir      (ir_q),
      .c_flag  (c_q),
      .z_flag  (z_flag),
      .state   (state)
   );

   opc5_regfile u_regfile (
      .clk    (clk),
      .radr_a (ir_q.dst),
      .radr_b (ir_q.src),
      .pc     (pc_q),
      .we     (rf_we),
      .wadr   (ir_q.dst),
      .wdata  (alu_out.result),
      .rdata_a(rdata_a),
      .rdata_b(rdata_b)
   );

   opc5_alu u_alu (
      .op      (ir_q.opcode),
      .a       (rdata_a),
      .b       (operand),
      .carry_in(c_q),
      .out     (alu_out)
   );

   // ========================================
   // registers
   // ========================================
   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         pc_q <= '0;
      else if (in_fetch)
         pc_q <= pc_q + 1'b1;
      else if (in_exec)
         pc_q <= (ir_q.dst == 4'(PC_REG)) ? alu_out.result : pc_q + 1'b1;
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         c_q      <= 1'b0;
         result_q <= '0;
      end
      else if (in_exec)
      begin
         c_q      <= alu_out.carry;
         result_q <= alu_out.result;     // drives z
      end
   end

   always_ff @(posedge clk)
   begin
      case (state)
         st_fetch0, st_exec: or_q <= '0;
         st_fetch1, st_rdmem: or_q <= data;
         st_ea_ed: or_q <= rdata_b + or_q;
         default: or_q <= or_q;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if ((state == st_fetch0) || in_exec)
         ir_q <= bus_word;               // exec prefetches the next word
   end

   // while storing, the bus carries the processor's word and nothing else
   a_bus_drive: assert property (@(posedge clk) disable iff (!reset_b)
      !rnw |-> (data === rdata_a))
      else $error("bus contention during a processor write");

endmodule

`default_nettype wire

/* source/opc5_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module opc5_memory
   import opc5_pkg::*;
(
   input  logic              clk,
   input  logic [DATA_W-1:0] address,
   input  logic              rnw,
   inout  wire logic [DATA_W-1:0] data,
   input  logic              load_en,
   input  logic [DATA_W-1:0] load_address,
   input  logic [DATA_W-1:0] load_data
);

   logic [DATA_W-1:0]     mem [1 << MEM_ADDR_W];
   logic [MEM_ADDR_W-1:0] bus_index;
   logic [MEM_ADDR_W-1:0] load_index;
   logic                  drive_en;

   assign bus_index  = address[MEM_ADDR_W-1:0];      // upper bits alias
   assign load_index = load_address[MEM_ADDR_W-1:0];
   assign drive_en   = rnw && !load_en;

   // asynchronous read
   assign data = drive_en ? mem[bus_index] : 'z;

   always_ff @(posedge clk)
   begin
      if (load_en)
         mem[load_index] <= load_data;   // loader wins
      else if (!rnw)
         mem[bus_index] <= data;
   end

endmodule

`default_nettype wire

/* source/opc5_system.sv */
`timescale 1ns/1ps
`default_nettype none

module opc5_system
   import opc5_pkg::*;
(
   input  logic              clk,
   input  logic              reset_b,
   input  logic              load_en,
   input  logic [DATA_W-1:0] load_address,
   input  logic [DATA_W-1:0] load_data,
   output logic              store_valid,
   output logic [DATA_W-1:0] store_address,
   output logic [DATA_W-1:0] store_data
);

   wire logic [DATA_W-1:0] bus_data;
   logic [DATA_W-1:0]      bus_address;
   logic                   bus_rnw;

   opc5_cpu u_cpu (
      .clk    (clk),
      .reset_b(reset_b),
      .data   (bus_data),
      .address(bus_address),
      .rnw    (bus_rnw)
   );

   opc5_memory u_memory (
      .clk         (clk),
      .address     (bus_address),
      .rnw         (bus_rnw),
      .data        (bus_data),
      .load_en     (load_en),
      .load_address(load_address),
      .load_data   (load_data)
   );

   // store monitor
   assign store_valid   = !bus_rnw;
   assign store_address = bus_address;
   assign store_data    = bus_data;

endmodule

`default_nettype wire

/* testbench/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// ========================================
// instruction assembly helpers
// ========================================
function automatic logic [15:0] encode(input logic [2:0] pred, input logic two_word,
                                       input logic indirect, input opc5_op_t op,
                                       input logic [3:0] src, input logic [3:0] dst);
   return {pred, two_word, indirect, op, src, dst};
endfunction

task automatic emit_word(input int p, input logic [15:0] w);
   prog_mem[p][prog_len[p]] = w;
   prog_len[p] = prog_len[p] + 1;
endtask

task automatic expect_store(input int p, input logic [15:0] a, input logic [15:0] d);
   exp_address[p][store_count[p]] = a;
   exp_data[p][store_count[p]]    = d;
   store_count[p] = store_count[p] + 1;
endtask

task automatic load_immediate(input int p, input logic [3:0] dst, input logic [15:0] imm);
   emit_word(p, encode(pr_always, 1'b1, 1'b0, op_ld, 4'd0, dst));
   emit_word(p, imm);
endtask

task automatic op_immediate(input int p, input logic [2:0] pred, input opc5_op_t op,
                            input logic [3:0] dst, input logic [15:0] imm);
   emit_word(p, encode(pred, 1'b1, 1'b0, op, 4'd0, dst));
   emit_word(p, imm);
endtask

task automatic op_register(input int p, input opc5_op_t op, input logic [3:0] src,
                           input logic [3:0] dst);
   emit_word(p, encode(pr_always, 1'b0, 1'b0, op, src, dst));
endtask

// stores register dst at src + imm
task automatic store_register(input int p, input logic [2:0] pred, input logic [3:0] src,
                              input logic [3:0] dst, input logic [15:0] imm);
   emit_word(p, encode(pred, 1'b1, 1'b0, op_sto, src, dst));
   emit_word(p, imm);
endtask

task automatic halt_loop(input int p);
   int here;
   here = prog_len[p];
   op_immediate(p, pr_always, op_ld, 4'd15, 16'(here));   // jump to itself
endtask

// ========================================
// fixed programs
// ========================================
task automatic build_program_table();
   for (int i = 0; i < NPROG; i++)
   begin
      prog_len[i]    = 0;
      store_count[i] = 0;
   end

   prog_name[0] = "reset_r0";
   store_register(0, pr_always, 4'd0, 4'd0, 16'h0100);
   load_immediate(0, 4'd1, 16'h1234);
   store_register(0, pr_always, 4'd0, 4'd1, 16'h0101);
   halt_loop(0);
   expect_store(0, 16'h0100, 16'h0000);
   expect_store(0, 16'h0101, 16'h1234);

   prog_name[1] = "add_adc_ror";
   load_immediate(1, 4'd1, 16'hffff);
   op_immediate(1, pr_always, op_add, 4'd1, 16'h0002);   // 0x0001, carry set
   op_immediate(1, pr_always, op_adc, 4'd1, 16'h0010);   // 0x0012, carry clear
   store_register(1, pr_always, 4'd0, 4'd1, 16'h0110);
   op_immediate(1, pr_always, op_add, 4'd1, 16'hffff);   // 0x0011, carry set
   op_immediate(1, pr_always, op_ror, 4'd3, 16'h0004);   // carry enters bit 15
   store_register(1, pr_always, 4'd0, 4'd3, 16'h0111);
   halt_loop(1);
   expect_store(1, 16'h0110, 16'h0012);
   expect_store(1, 16'h0111, 16'h8002);

   prog_name[2] = "logic_ops";
   load_immediate(2, 4'd1, 16'h0f0f);
   load_immediate(2, 4'd2, 16'h3c3c);
   op_register(2, op_ld, 4'd1, 4'd3);
   op_register(2, op_and, 4'd2, 4'd3);
   store_register(2, pr_always, 4'd0, 4'd3, 16'h0120);
   op_register(2, op_or, 4'd2, 4'd1);
   store_register(2, pr_always, 4'd0, 4'd1, 16'h0121);
   op_register(2, op_xor, 4'd3, 4'd2);
   store_register(2, pr_always, 4'd0, 4'd2, 16'h0122);
   halt_loop(2);
   expect_store(2, 16'h0120, 16'h0c0c);
   expect_store(2, 16'h0121, 16'h3f3f);
   expect_store(2, 16'h0122, 16'h3030);

   prog_name[3] = "predicates";
   load_immediate(3, 4'd2, 16'h0055);
   load_immediate(3, 4'd1, 16'h0000);                    // z set, c clear
   op_immediate(3, pr_if_nz, op_ld, 4'd2, 16'hc701);     // skipped, imm looks like a store
   store_register(3, pr_if_z, 4'd0, 4'd2, 16'h0130);
   op_immediate(3, pr_always, op_add, 4'd2, 16'hffff);   // 0x0054, carry set
   store_register(3, pr_if_c, 4'd0, 4'd2, 16'h0131);
   store_register(3, pr_if_nc, 4'd0, 4'd2, 16'h0132);
   halt_loop(3);
   expect_store(3, 16'h0130, 16'h0055);
   expect_store(3, 16'h0131, 16'h0054);

   prog_name[4] = "ea_load";
   load_immediate(4, 4'd4, 16'h0140);
   load_immediate(4, 4'd1, 16'hbeef);
   store_register(4, pr_always, 4'd4, 4'd1, 16'h0003);
   emit_word(4, encode(pr_always, 1'b1, 1'b1, op_ld, 4'd4, 4'd2));
   emit_word(4, 16'h0003);
   store_register(4, pr_always, 4'd0, 4'd2, 16'h0144);
   halt_loop(4);
   expect_store(4, 16'h0143, 16'hbeef);
   expect_store(4, 16'h0144, 16'hbeef);

   prog_name[5] = "jump";
   op_immediate(5, pr_always, op_ld, 4'd15, 16'h0004);
   store_register(5, pr_always, 4'd0, 4'd0, 16'h0150);
   load_immediate(5, 4'd1, 16'h00a5);
   op_immediate(5, pr_always, op_add, 4'd15, 16'h0002);  // relative, lands on word 10
   store_register(5, pr_always, 4'd0, 4'd0, 16'h0151);
   store_register(5, pr_always, 4'd0, 4'd1, 16'h0152);
   halt_loop(5);
   expect_store(5, 16'h0152, 16'h00a5);
endtask

`endif

/* testbench/tb_opc5_system.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_opc5_system
   import opc5_pkg::*;
();

   localparam int NPROG       = 7;
   localparam int MAX_WORDS   = 16;
   localparam int MAX_STORES  = 8;
   localparam int STORE_LIMIT = 500;
   localparam int QUIET_TIME  = 20;

   localparam logic [2:0] pr_always = 3'b110;
   localparam logic [2:0] pr_if_z   = 3'b100;
   localparam logic [2:0] pr_if_nz  = 3'b101;
   localparam logic [2:0] pr_if_c   = 3'b010;
   localparam logic [2:0] pr_if_nc  = 3'b011;

   logic        clk;
   logic        reset_b;
   logic        load_en;
   logic [15:0] load_address;
   logic [15:0] load_data;
   logic        store_valid;
   logic [15:0] store_address;
   logic [15:0] store_data;

   string       prog_name   [NPROG];
   logic [15:0] prog_mem    [NPROG][MAX_WORDS];
   int          prog_len    [NPROG];
   int          store_count [NPROG];
   logic [15:0] exp_address [NPROG][MAX_STORES];
   logic [15:0] exp_data    [NPROG][MAX_STORES];

   int          errors;
   int          timeouts;
   int          checks;
   logic [31:0] lcg_state;

   `include "tb_programs.svh"

   opc5_system uut (
      .clk          (clk),
      .reset_b      (reset_b),
      .load_en      (load_en),
      .load_address (load_address),
      .load_data    (load_data),
      .store_valid  (store_valid),
      .store_address(store_address),
      .store_data   (store_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [15:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:15];
   endfunction

   // ========================================
   // random immediate program
   // ========================================
   task automatic build_random_program(input int p);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] c;
      logic [15:0] r;
      logic [15:0] ad1;
      logic [15:0] ad2;
      logic [15:0] ad3;
      logic [16:0] sum1;
      logic [16:0] sum2;
      logic [16:0] sum3;
      a = next_random();
      b = next_random();
      c = next_random();
      r = next_random();
      ad1 = {8'h02, r[7:0]};
      r = next_random();
      ad2 = {8'h03, 1'b0, r[6:0]};
      r = next_random();
      ad3 = {8'h03, 1'b1, r[6:0]};
      sum1 = {1'b0, a} + {1'b0, b};
      sum2 = {1'b0, sum1[15:0]} + {1'b0, c};
      sum3 = {1'b0, sum2[15:0]} + 17'(sum2[16]);     // adc with zero immediate
      prog_name[p]   = "random_sum";
      prog_len[p]    = 0;
      store_count[p] = 0;
      load_immediate(p, 4'd1, a);
      op_immediate(p, pr_always, op_add, 4'd1, b);
      store_register(p, pr_always, 4'd0, 4'd1, ad1);
      op_immediate(p, pr_always, op_add, 4'd1, c);
      store_register(p, pr_always, 4'd0, 4'd1, ad2);
      op_immediate(p, pr_always, op_adc, 4'd1, 16'h0000);
      store_register(p, pr_always, 4'd0, 4'd1, ad3);
      halt_loop(p);
      expect_store(p, ad1, sum1[15:0]);
      expect_store(p, ad2, sum2[15:0]);
      expect_store(p, ad3, sum3[15:0]);
   endtask

   // ========================================
   // load, run and check one program
   // ========================================
   task automatic load_program(input int p);
      @(posedge clk);
      reset_b <= 1'b0;
      for (int i = 0; i < prog_len[p]; i++)
      begin
         @(posedge clk);
         load_en      <= 1'b1;
         load_address <= 16'(i);
         load_data    <= prog_mem[p][i];
      end
      @(posedge clk);
      load_en <= 1'b0;
      repeat (4)
      begin
         @(negedge clk);
         checks++;
         assert (store_valid === 1'b0)
         else
         begin
            $display("%s: store_valid was high while reset was held", prog_name[p]);
            errors++;
         end
      end
      @(posedge clk);
      reset_b <= 1'b1;
   endtask

   task automatic collect_stores(input int p);
      int got;
      int cycles;
      got    = 0;
      cycles = 0;
      while ((got < store_count[p]) && (cycles < STORE_LIMIT))
      begin
         @(negedge clk);                 // bus is settled mid cycle
         cycles++;
         if (store_valid === 1'b1)
         begin
            checks += 2;
            assert (store_address === exp_address[p][got])
            else
            begin
               $display("ERROR %s store %0d address: expected %h, actual %h",
                        prog_name[p], got, exp_address[p][got], store_address);
               errors++;
            end
            assert (store_data === exp_data[p][got])
            else
            begin
               $display("ERROR %s store %0d data: expected %h, actual %h",
                        prog_name[p], got, exp_data[p][got], store_data);
               errors++;
            end
            got++;
         end
      end
      if (got < store_count[p])
      begin
         $display("%s: timed out after %0d cycles, only %0d of %0d stores arrived",
                  prog_name[p], cycles, got, store_count[p]);
         timeouts++;
      end
   endtask

   // the program now spins in its halt loop and must stay silent
   task automatic check_quiet(input int p);
      repeat (QUIET_TIME)
      begin
         @(negedge clk);
         checks++;
         assert (store_valid === 1'b0)
         else
         begin
            $display("%s: unexpected extra store to %h of %h", prog_name[p],
                     store_address, store_data);
            errors++;
         end
      end
   endtask

   initial
   begin
      reset_b      = 1'b0;
      load_en      = 1'b0;
      load_address = '0;
      load_data    = '0;
      errors       = 0;
      timeouts     = 0;
      checks       = 0;
      lcg_state    = 32'd63;
      build_program_table();
      build_random_program(NPROG - 1);
      for (int p = 0; p < NPROG; p++)
      begin
         load_program(p);
         collect_stores(p);
         check_quiet(p);
      end
      $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
      if ((errors == 0) && (timeouts == 0))
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+testbench
source/opc5_pkg.sv
source/opc5_alu.sv
source/opc5_regfile.sv
source/opc5_control.sv
source/opc5_cpu.sv
source/opc5_memory.sv
source/opc5_system.sv
testbench/tb_opc5_system.sv

/* Bender.yml */
package:
  name: opc5_system

sources:
  # package first, then the blocks, then the top level
  - source/opc5_pkg.sv
  - source/opc5_alu.sv
  - source/opc5_regfile.sv
  - source/opc5_control.sv
  - source/opc5_cpu.sv
  - source/opc5_memory.sv
  - source/opc5_system.sv

  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_opc5_system.sv
